// ==== hdl/decode.sv ====
//**********************************************************
// Decode stage
// Control decode, register file with write bypass, load-use
// stall, halt and illegal-opcode detection
//**********************************************************
`timescale 1ns/1ps
`include "proc_params.svh"

module decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    ifIdBus.receiver          ifId,
    idExBus.driver            idEx,
    memWbBus.receiver         memWb,
    input  proc_pkg::regIdx_t exLoadRd,
    input  logic              exLoadValid,
    output logic              stall,
    output logic              halt,
    output logic              err
);
    import proc_pkg::*;

    word_t   regs [`REG_COUNT];
    opcode_t op;
    regIdx_t rd;
    regIdx_t rs;
    regIdx_t rtIdx;
    word_t   imm;
    word_t   rsVal;
    word_t   rtVal;
    aluOp_t  aluOp;
    logic    useImm, regWrite, memRead, memWrite, branch, isHalt, illegal;
    logic    readsRs, readsRt;
    logic    wbWrite;
    logic    take;

    assign op = opcode_t'(ifId.instr[15:12]);
    assign rd = ifId.instr[11:9];
    assign rs = ifId.instr[8:6];
    // Stores read their data register through the second port
    assign rtIdx = (op == OP_ST) ? rd : ifId.instr[5:3];
    assign imm = {{(`DATA_WIDTH-6){ifId.instr[5]}}, ifId.instr[5:0]};

    always_comb begin
        aluOp = ALU_ADD;
        useImm = 1'b0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        branch = 1'b0;
        isHalt = 1'b0;
        illegal = 1'b0;
        readsRs = 1'b0;
        readsRt = 1'b0;
        case (op)
            OP_NOP:  ;
            OP_ADD:  begin regWrite = 1'b1; readsRs = 1'b1; readsRt = 1'b1; end
            OP_SUB:  begin aluOp = ALU_SUB; regWrite = 1'b1; readsRs = 1'b1; readsRt = 1'b1; end
            OP_AND:  begin aluOp = ALU_AND; regWrite = 1'b1; readsRs = 1'b1; readsRt = 1'b1; end
            OP_XOR:  begin aluOp = ALU_XOR; regWrite = 1'b1; readsRs = 1'b1; readsRt = 1'b1; end
            OP_ADDI: begin useImm = 1'b1; regWrite = 1'b1; readsRs = 1'b1; end
            OP_LD:   begin useImm = 1'b1; regWrite = 1'b1; memRead = 1'b1; readsRs = 1'b1; end
            OP_ST:   begin useImm = 1'b1; memWrite = 1'b1; readsRs = 1'b1; readsRt = 1'b1; end
            OP_BEQZ: begin branch = 1'b1; readsRs = 1'b1; end
            OP_HALT: isHalt = 1'b1;
            default: illegal = 1'b1;
        endcase
    end

    // Load in execute feeding this instruction
    assign stall = ifId.valid && exLoadValid &&
                   ((readsRs && rs == exLoadRd) || (readsRt && rtIdx == exLoadRd));

    // Register file, written from writeback
    assign wbWrite = memWb.valid && memWb.regWrite;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[memWb.rd] <= memWb.data;
        end
    end

    // Same-cycle write shows up on the read ports
    assign rsVal = (wbWrite && memWb.rd == rs) ? memWb.data : regs[rs];
    assign rtVal = (wbWrite && memWb.rd == rtIdx) ? memWb.data : regs[rtIdx];

    // Entry moves on to execute
    assign take = ifId.valid && !flush && !stall && !halt;

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.valid <= 1'b0;
            halt <= 1'b0;
            err <= 1'b0;
        end else begin
            idEx.valid <= take;
            if (take && isHalt) begin
                halt <= 1'b1;
            end
            if (take && illegal) begin
                err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        idEx.pc <= ifId.pc;
        idEx.rs <= rs;
        idEx.rt <= rtIdx;
        idEx.rd <= rd;
        idEx.rsVal <= rsVal;
        idEx.rtVal <= rtVal;
        idEx.imm <= imm;
        idEx.aluOp <= aluOp;
        idEx.useImm <= useImm;
        idEx.regWrite <= regWrite;
        idEx.memRead <= memRead;
        idEx.memWrite <= memWrite;
        idEx.branch <= branch;
        idEx.halt <= isHalt;
    end

endmodule

// ==== hdl/execute.sv ====
//**********************************************************
// Execute stage
// Operand forwarding, ALU, branch resolution and the
// execute/memory pipeline register
//**********************************************************
`timescale 1ns/1ps

module execute (
    input  logic          clk,
    input  logic          reset,
    idExBus.receiver      idEx,
    exMemBus.driver       exMem,
    memWbBus.receiver     memWb,
    output logic          flush,
    output proc_pkg::pc_t target
);
    import proc_pkg::*;

    logic  exFwdOk, wbFwdOk;
    word_t opA;
    word_t fwdB;
    word_t opB;
    word_t result;

    // Loads in execute/memory are excluded, the stall covers them
    assign exFwdOk = exMem.valid && exMem.regWrite && !exMem.memRead;
    assign wbFwdOk = memWb.valid && memWb.regWrite;

    // Youngest producer wins
    always_comb begin
        if (exFwdOk && exMem.rd == idEx.rs) begin
            opA = exMem.result;
        end else if (wbFwdOk && memWb.rd == idEx.rs) begin
            opA = memWb.data;
        end else begin
            opA = idEx.rsVal;
        end
    end

    always_comb begin
        if (exFwdOk && exMem.rd == idEx.rt) begin
            fwdB = exMem.result;
        end else if (wbFwdOk && memWb.rd == idEx.rt) begin
            fwdB = memWb.data;
        end else begin
            fwdB = idEx.rtVal;
        end
    end

    assign opB = idEx.useImm ? idEx.imm : fwdB;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: result = opA + opB;
            ALU_SUB: result = opA - opB;
            ALU_AND: result = opA & opB;
            ALU_XOR: result = opA ^ opB;
            default: result = '0;
        endcase
    end

    // Branch taken kills the two younger entries
    assign flush = idEx.valid && idEx.branch && (opA == '0);
    assign target = idEx.pc + pc_t'(1) + pc_t'(idEx.imm);

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
        end
    end

    always_ff @(posedge clk) begin
        exMem.result <= result;
        // Store data is the forwarded second operand
        exMem.storeData <= fwdB;
        exMem.rd <= idEx.rd;
        exMem.regWrite <= idEx.regWrite;
        exMem.memRead <= idEx.memRead;
        exMem.memWrite <= idEx.memWrite;
        exMem.halt <= idEx.halt;
    end

endmodule

// ==== hdl/fetch.sv ====
//**********************************************************
// Fetch stage
// Program counter, instruction memory with a load port,
// and the fetch/decode pipeline register
//**********************************************************
`timescale 1ns/1ps
`include "proc_params.svh"

module fetch (
    input  logic            clk,
    input  logic            reset,
    input  logic            progWrite,
    input  proc_pkg::pc_t   progAddr,
    input  proc_pkg::instr_t progData,
    input  logic            stall,
    input  logic            flush,
    input  logic            halt,
    input  proc_pkg::pc_t   target,
    ifIdBus.driver          ifId
);
    import proc_pkg::*;

    pc_t    pc;
    instr_t imem [`IMEM_DEPTH];
    logic   advance;

    // Move on unless decode holds us or the core has stopped
    assign advance = !flush && !stall && !halt;

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ifId.valid <= 1'b0;
        end else if (flush) begin
            // Redirect to the branch target, drop the wrong-path word
            pc <= target;
            ifId.valid <= 1'b0;
        end else if (advance) begin
            pc <= pc + pc_t'(1);
            ifId.valid <= 1'b1;
        end
    end

    // Payload of the fetch/decode register
    always_ff @(posedge clk) begin
        if (advance) begin
            ifId.pc <= pc;
            ifId.instr <= imem[pc];
        end
    end

    // Program load port, usable at any time
    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;
        end
    end

endmodule

// ==== hdl/memory.sv ====
//**********************************************************
// Memory stage
// Data memory, writeback result select and the
// memory/writeback register
//**********************************************************
`timescale 1ns/1ps
`include "proc_params.svh"

module memory (
    input  logic      clk,
    input  logic      reset,
    exMemBus.receiver exMem,
    memWbBus.driver   memWb
);
    import proc_pkg::*;

    word_t  dmem [`DMEM_DEPTH];
    dAddr_t addr;
    logic   hold;

    // Low bits of the address sum
    assign addr = dAddr_t'(exMem.result);

    // A halt entry parks in the register, which keeps halted high
    assign hold = memWb.valid && memWb.halt;

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.memWrite) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            memWb.valid <= 1'b0;
        end else if (!hold) begin
            memWb.valid <= exMem.valid;
        end
    end

    // Result select, load data or ALU result
    always_ff @(posedge clk) begin
        if (!hold) begin
            memWb.rd <= exMem.rd;
            memWb.regWrite <= exMem.regWrite;
            memWb.halt <= exMem.halt;
            memWb.data <= exMem.memRead ? dmem[addr] : exMem.result;
        end
    end

endmodule

// ==== hdl/proc.sv ====
//**********************************************************
// Processor top level
// Five-stage in-order 16-bit core, with retire, halt and
// error brought out to plain ports
//**********************************************************
`timescale 1ns/1ps

module proc (
    input  logic              clk,
    input  logic              reset,
    input  logic              progWrite,
    input  proc_pkg::pc_t     progAddr,
    input  proc_pkg::instr_t  progData,
    output logic              retireValid,
    output proc_pkg::regIdx_t retireReg,
    output proc_pkg::word_t   retireData,
    output logic              halted,
    output logic              err
);
    import proc_pkg::*;

    logic stall;
    logic flush;
    logic decodeHalt;
    pc_t  target;

    ifIdBus  ifIdLink ();
    idExBus  idExLink ();
    exMemBus exMemLink ();
    memWbBus memWbLink ();

    fetch fetchInst (
        .clk(clk), .reset(reset),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .stall(stall), .flush(flush), .halt(decodeHalt), .target(target),
        .ifId(ifIdLink)
    );

    // Load-use check looks at the entry now in execute
    decode decodeInst (
        .clk(clk), .reset(reset), .flush(flush),
        .ifId(ifIdLink), .idEx(idExLink), .memWb(memWbLink),
        .exLoadRd(idExLink.rd), .exLoadValid(idExLink.valid && idExLink.memRead),
        .stall(stall), .halt(decodeHalt), .err(err)
    );

    execute executeInst (
        .clk(clk), .reset(reset),
        .idEx(idExLink), .exMem(exMemLink), .memWb(memWbLink),
        .flush(flush), .target(target)
    );

    memory memoryInst (
        .clk(clk), .reset(reset),
        .exMem(exMemLink), .memWb(memWbLink)
    );

    // Writeback seen from outside
    assign retireValid = memWbLink.valid && memWbLink.regWrite;
    assign retireReg = memWbLink.rd;
    assign retireData = memWbLink.data;
    assign halted = memWbLink.valid && memWbLink.halt;

endmodule

// ==== hdl/proc_pkg.sv ====
//**********************************************************
// Processor package
// Vector types, opcodes and ALU selectors of the core
//**********************************************************
`include "proc_params.svh"

package proc_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`DATA_WIDTH-1:0] instr_t;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] pc_t;
    typedef logic [$clog2(`DMEM_DEPTH)-1:0] dAddr_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;
    typedef logic [3:0] opcode_t;
    typedef logic [1:0] aluOp_t;

    // Fields: op 15..12, rd 11..9, rs 8..6, rt 5..3, imm 5..0 (signed)
    // LD   rd <= mem[rs + imm]
    // ST   mem[rs + imm] <= rd
    // BEQZ pc <= pc + 1 + imm when rs is zero
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_ADD  = 4'd1;
    localparam opcode_t OP_SUB  = 4'd2;
    localparam opcode_t OP_AND  = 4'd3;
    localparam opcode_t OP_XOR  = 4'd4;
    localparam opcode_t OP_ADDI = 4'd5;
    localparam opcode_t OP_LD   = 4'd6;
    localparam opcode_t OP_ST   = 4'd7;
    localparam opcode_t OP_BEQZ = 4'd8;
    localparam opcode_t OP_HALT = 4'd15;

    // ALU function select
    localparam aluOp_t ALU_ADD = 2'd0;
    localparam aluOp_t ALU_SUB = 2'd1;
    localparam aluOp_t ALU_AND = 2'd2;
    localparam aluOp_t ALU_XOR = 2'd3;

endpackage

// ==== hdl/stage_if.sv ====
//**********************************************************
// Pipeline register buses
// One interface per stage boundary, driven by the older
// stage and read by the younger one
//**********************************************************
`timescale 1ns/1ps

interface ifIdBus;
    import proc_pkg::*;

    logic   valid;
    pc_t    pc;
    instr_t instr;

    modport driver (output valid, pc, instr);
    modport receiver (input valid, pc, instr);
endinterface

interface idExBus;
    import proc_pkg::*;

    logic    valid;
    pc_t     pc;
    // For ST the rt slot carries the rd index, i.e. the store data register
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    word_t   rsVal;
    word_t   rtVal;
    word_t   imm;
    aluOp_t  aluOp;
    logic    useImm;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    branch;
    logic    halt;

    modport driver (output valid, pc, rs, rt, rd, rsVal, rtVal, imm, aluOp, useImm,
                    regWrite, memRead, memWrite, branch, halt);
    modport receiver (input valid, pc, rs, rt, rd, rsVal, rtVal, imm, aluOp, useImm,
                      regWrite, memRead, memWrite, branch, halt);
endinterface

interface exMemBus;
    import proc_pkg::*;

    logic    valid;
    word_t   result;
    word_t   storeData;
    regIdx_t rd;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    halt;

    modport driver (output valid, result, storeData, rd, regWrite, memRead, memWrite, halt);
    modport receiver (input valid, result, storeData, rd, regWrite, memRead, memWrite, halt);
endinterface

interface memWbBus;
    import proc_pkg::*;

    logic    valid;
    regIdx_t rd;
    word_t   data;
    logic    regWrite;
    logic    halt;

    modport driver (output valid, rd, data, regWrite, halt);
    modport receiver (input valid, rd, data, regWrite, halt);
endinterface

// ==== include/proc_params.svh ====
//**********************************************************
// Processor parameters
// Word width, register count and memory depths of the core
//**********************************************************
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Data word, also the instruction width
`define DATA_WIDTH 16

// Architectural registers
`define REG_COUNT 8

// Memory sizes in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`endif

// ==== sim.f ====
+incdir+include
hdl/proc_pkg.sv
hdl/stage_if.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
tb/proc_tb.sv

// ==== tb/proc_tb.sv ====
//**********************************************************
// Processor testbench
// Runs directed and random programs to halt and checks each
// retire strobe against an ISA model
//**********************************************************
`timescale 1ns/1ps
`include "proc_params.svh"

module proc_tb;
    import proc_pkg::*;

    logic        clk;
    logic        reset;
    logic        progWrite;
    pc_t         progAddr;
    instr_t      progData;
    logic        retireValid;
    regIdx_t     retireReg;
    word_t       retireData;
    logic        halted;
    logic        err;

    instr_t      prog [$];
    regIdx_t     expReg [$];
    word_t       expData [$];
    logic        expErr;
    logic [31:0] randState;
    int          errors;
    int          failedTests;
    int          testCount;
    logic        timedOut;
    string       testName;

    proc proc_inst (
        .clk(clk), .reset(reset),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
        .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Immediate form, R-type leaves the low three bits zero
    function automatic instr_t makeI(opcode_t op, regIdx_t rd, regIdx_t rs, logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic instr_t makeR(opcode_t op, regIdx_t rd, regIdx_t rs, regIdx_t rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Steps the ISA over prog and records every register write in order
    task automatic runModel();
        word_t  regs [`REG_COUNT];
        word_t  dmem [`DMEM_DEPTH];
        pc_t    pc;
        instr_t ins;
        word_t  a;
        word_t  b;
        word_t  imm;
        word_t  val;
        logic   wr;
        logic   done;
        expReg.delete();
        expData.delete();
        expErr = 1'b0;
        pc = '0;
        done = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] = '0;
        end
        for (int steps = 0; steps < 1000 && !done; steps++) begin
            ins = prog[pc];
            a = regs[ins[8:6]];
            b = regs[ins[5:3]];
            imm = {{(`DATA_WIDTH-6){ins[5]}}, ins[5:0]};
            val = '0;
            wr = 1'b0;
            pc = pc + pc_t'(1);
            case (ins[15:12])
                OP_NOP:  ;
                OP_ADD:  begin val = a + b; wr = 1'b1; end
                OP_SUB:  begin val = a - b; wr = 1'b1; end
                OP_AND:  begin val = a & b; wr = 1'b1; end
                OP_XOR:  begin val = a ^ b; wr = 1'b1; end
                OP_ADDI: begin val = a + imm; wr = 1'b1; end
                OP_LD:   begin val = dmem[dAddr_t'(a + imm)]; wr = 1'b1; end
                OP_ST:   dmem[dAddr_t'(a + imm)] = regs[ins[11:9]];
                OP_BEQZ: if (a == '0) pc = pc + pc_t'(imm);
                OP_HALT: done = 1'b1;
                default: expErr = 1'b1;
            endcase
            if (wr) begin
                regs[ins[11:9]] = val;
                expReg.push_back(ins[11:9]);
                expData.push_back(val);
            end
        end
    endtask

    // Retire strobes sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!reset && retireValid === 1'b1) begin
            if (expReg.size() == 0) begin
                $display("Retire strobe seen with no register write left in the model");
                errors++;
            end else begin
                assert (retireReg == expReg[0]) else begin
                    $display("** Error: retireReg expected %h got %h", expReg[0], retireReg);
                    errors++;
                end
                assert (retireData == expData[0]) else begin
                    $display("** Error: retireData expected %h got %h", expData[0], retireData);
                    errors++;
                end
                void'(expReg.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    // Halt freezes the pipeline for good
    assert property (@(posedge clk) disable iff (reset) halted |=> halted && !retireValid)
        else begin
            $display("Retire strobe or halted drop seen after the core halted");
            errors++;
        end

    task automatic buildRandom();
        opcode_t ops [5];
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI};
        for (int i = 0; i < 40; i++) begin
            randState = xorshift(randState);
            prog.push_back(makeI(ops[randState % 5], randState[18:16], randState[21:19],
                                 randState[27:22]));
        end
        prog.push_back(makeR(OP_HALT, 3'd0, 3'd0, 3'd0));
    endtask

    // Loads prog under reset, runs to halt and settles the checks
    task automatic runTest(input string name);
        int startErrors;
        int n;
        startErrors = errors;
        runModel();
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            progWrite <= 1'b1;
            progAddr <= pc_t'(i);
            progData <= prog[i];
            @(posedge clk);
        end
        progWrite <= 1'b0;
        @(posedge clk);
        reset <= 1'b0;
        n = 0;
        @(negedge clk);
        while (halted !== 1'b1 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (halted !== 1'b1) begin
            $display("Test %s timed out waiting for halted", name);
            timedOut = 1'b1;
            errors++;
        end else begin
            // A few idle cycles to catch stray strobes
            repeat (3) @(negedge clk);
            assert (err == expErr) else begin
                $display("** Error: err expected %h got %h", expErr, err);
                errors++;
            end
            if (expReg.size() != 0) begin
                $display("%0d expected register writes never retired", expReg.size());
                errors++;
            end
        end
        testCount++;
        if (errors != startErrors) begin
            failedTests++;
        end
        $display("Test %0d %s: %s", testCount, name, (errors == startErrors) ? "ok" : "failed");
    endtask

    initial begin
        reset = 1'b1;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        errors = 0;
        failedTests = 0;
        testCount = 0;
        timedOut = 1'b0;
        randState = 32'h2bd8;
        repeat (2) @(posedge clk);
        for (int t = 0; t < 6 && !timedOut; t++) begin
            prog.delete();
            case (t)
                0: begin
                    testName = "dependent ALU chain";
                    prog = '{makeI(OP_ADDI, 1, 0, 6'd5), makeI(OP_ADDI, 2, 1, 6'd3),
                             makeR(OP_ADD, 3, 1, 2), makeR(OP_SUB, 4, 3, 1),
                             makeR(OP_XOR, 5, 4, 2), makeR(OP_AND, 6, 3, 4),
                             makeR(OP_ADD, 7, 1, 6), makeI(OP_ADDI, 1, 1, 6'h3f),
                             makeR(OP_ADD, 2, 1, 7), makeR(OP_HALT, 0, 0, 0)};
                end
                1: begin
                    testName = "load-use stall";
                    prog = '{makeI(OP_ADDI, 1, 0, 6'd9), makeI(OP_ADDI, 2, 0, 6'd20),
                             makeI(OP_ST, 1, 2, 6'd4), makeI(OP_LD, 3, 2, 6'd4),
                             makeR(OP_ADD, 4, 3, 1), makeR(OP_ADD, 5, 4, 3),
                             makeR(OP_HALT, 0, 0, 0)};
                end
                2: begin
                    testName = "store then load";
                    prog = '{makeI(OP_ADDI, 1, 0, 6'h39), makeI(OP_ST, 1, 0, 6'd12),
                             makeI(OP_LD, 2, 0, 6'd12), makeR(OP_ADD, 3, 2, 1),
                             makeR(OP_HALT, 0, 0, 0)};
                end
                3: begin
                    testName = "branch taken and not taken";
                    prog = '{makeI(OP_ADDI, 1, 0, 6'd2), makeI(OP_BEQZ, 0, 0, 6'd2),
                             makeI(OP_ADDI, 2, 0, 6'd7), makeI(OP_ADDI, 3, 0, 6'd7),
                             makeI(OP_BEQZ, 0, 1, 6'd2), makeI(OP_ADDI, 4, 1, 6'd1),
                             makeI(OP_ADDI, 5, 1, 6'd2), makeR(OP_HALT, 0, 0, 0)};
                end
                4: begin
                    testName = "illegal opcode and halt";
                    prog = '{makeI(OP_ADDI, 1, 0, 6'd3), 16'h9e3f,
                             makeI(OP_ADDI, 2, 1, 6'd4), makeR(OP_HALT, 0, 0, 0),
                             makeI(OP_ADDI, 3, 0, 6'd1)};
                end
                default: begin
                    testName = "random ALU program";
                    buildRandom();
                end
            endcase
            runTest(testName);
        end
        $display("Tests run %0d, failed %0d, errors %0d", testCount, failedTests, errors);
        if (errors == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
